// File: verilog/mastermind_pkg.sv
package mastermind_pkg;

    // Peg and word geometry
    localparam int PEG_W    = 3;                // Eight colours
    localparam int NUM_PEGS = 4;
    localparam int CODE_W   = PEG_W * NUM_PEGS;
    localparam int SLOT_W   = 2;                // Slot or score step index

    // Red and white counts hold 0 to 4
    localparam int COUNT_W = 3;

    localparam int SEG_W = 7;

    // Step tick period in clocks
    localparam int TICK_CYCLES_DEFAULT = 1_000_000;

    typedef enum logic [4:0] {
        CODE_WAIT_PRESS    = 5'd0,
        CODE_WAIT_RELEASE  = 5'd1,
        GUESS_WAIT_PRESS   = 5'd2,
        GUESS_WAIT_RELEASE = 5'd3,
        SCORE              = 5'd4,
        REPORT             = 5'd5
    } state_t;

endpackage

// File: verilog/tick_timer.sv
`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_CYCLES = mastermind_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic clock_i,
    input  logic resetn_i,
    output logic tick_o
);
    localparam int             CNT_W = $clog2(TICK_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(TICK_CYCLES - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clock_i) begin
        if (!resetn_i) begin
            count_q <= '0;
        end else if (count_q == LAST) begin
            count_q <= '0;                  // Wrap
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign tick_o = (count_q == LAST);

    // A tick lasts one clock
    generate
        if (TICK_CYCLES > 1) begin : g_tick_check
            assert property (@(posedge clock_i) disable iff (!resetn_i)
                tick_o |=> !tick_o);
        end
    endgenerate

endmodule

// File: verilog/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                              clock_i,
    input  logic                              resetn_i,
    input  logic                              tick_i,
    input  logic                              load_i,
    output logic                              code_we_o,
    output logic                              guess_we_o,
    output logic                              score_clear_o,
    output logic                              score_step_o,
    output logic                              results_o,
    output logic [mastermind_pkg::SLOT_W-1:0] slot_o
);
    import mastermind_pkg::*;

    state_t            state_q;
    state_t            state_d;
    logic [SLOT_W-1:0] slot_q;
    logic [SLOT_W-1:0] slot_d;
    logic              last_slot;

    assign last_slot = (slot_q == SLOT_W'(NUM_PEGS - 1));
    assign slot_o    = slot_q;

    // Everything moves on a tick only
    always_comb begin
        state_d       = state_q;
        slot_d        = slot_q;
        code_we_o     = 1'b0;
        guess_we_o    = 1'b0;
        score_clear_o = 1'b0;
        score_step_o  = 1'b0;
        results_o     = 1'b0;
        if (tick_i) begin
            case (state_q)
                CODE_WAIT_PRESS: begin
                    if (load_i) begin
                        code_we_o = 1'b1;
                        state_d   = CODE_WAIT_RELEASE;
                    end
                end
                CODE_WAIT_RELEASE: begin
                    if (!load_i) begin
                        slot_d  = slot_q + 1'b1;    // Wraps to 0 after last peg
                        state_d = last_slot ? GUESS_WAIT_PRESS : CODE_WAIT_PRESS;
                    end
                end
                GUESS_WAIT_PRESS: begin
                    if (load_i) begin
                        guess_we_o    = 1'b1;
                        score_clear_o = last_slot;  // New guess complete
                        state_d       = GUESS_WAIT_RELEASE;
                    end
                end
                GUESS_WAIT_RELEASE: begin
                    if (!load_i) begin
                        slot_d  = slot_q + 1'b1;
                        state_d = last_slot ? SCORE : GUESS_WAIT_PRESS;
                    end
                end
                SCORE: begin
                    // One code peg per step, slot doubles as step index
                    score_step_o = 1'b1;
                    slot_d       = slot_q + 1'b1;
                    if (last_slot) begin
                        state_d = REPORT;
                    end
                end
                REPORT: begin
                    results_o = 1'b1;
                    state_d   = GUESS_WAIT_PRESS;
                end
                default: begin
                    state_d = CODE_WAIT_PRESS;
                    slot_d  = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (!resetn_i) begin
            state_q <= CODE_WAIT_PRESS;
            slot_q  <= '0;
        end else begin
            state_q <= state_d;
            slot_q  <= slot_d;
        end
    end

    assert property (@(posedge clock_i) disable iff (!resetn_i)
        !(code_we_o && guess_we_o));

    // Strobes never outlast the tick that made them
    assert property (@(posedge clock_i) disable iff (!resetn_i)
        (code_we_o || guess_we_o || score_clear_o || score_step_o || results_o) |-> tick_i);

endmodule

// File: verilog/peg_registers.sv
`timescale 1ns/1ps

module peg_registers (
    input  logic                              clock_i,
    input  logic                              resetn_i,
    input  logic                              code_we_i,
    input  logic                              guess_we_i,
    input  logic [mastermind_pkg::SLOT_W-1:0] slot_i,
    input  logic [mastermind_pkg::PEG_W-1:0]  peg_i,
    output logic [mastermind_pkg::CODE_W-1:0] code_o,
    output logic [mastermind_pkg::CODE_W-1:0] guess_o
);
    import mastermind_pkg::*;

    logic [CODE_W-1:0] code_q;
    logic [CODE_W-1:0] guess_q;

    // Zeroed so the display starts at 0
    always_ff @(posedge clock_i) begin
        if (!resetn_i) begin
            code_q  <= '0;
            guess_q <= '0;
        end else begin
            if (code_we_i) begin
                code_q[slot_i*PEG_W +: PEG_W] <= peg_i;
            end
            if (guess_we_i) begin
                guess_q[slot_i*PEG_W +: PEG_W] <= peg_i;
            end
        end
    end

    assign code_o  = code_q;    // Kept until reset
    assign guess_o = guess_q;

endmodule

// File: verilog/peg_scorer.sv
`timescale 1ns/1ps

module peg_scorer (
    input  logic                               clock_i,
    input  logic                               resetn_i,
    input  logic                               clear_i,
    input  logic                               step_i,
    input  logic [mastermind_pkg::SLOT_W-1:0]  step_idx_i,
    input  logic [mastermind_pkg::CODE_W-1:0]  code_i,
    input  logic [mastermind_pkg::CODE_W-1:0]  guess_i,
    output logic [mastermind_pkg::COUNT_W-1:0] red_o,
    output logic [mastermind_pkg::COUNT_W-1:0] white_o
);
    import mastermind_pkg::*;

    logic [NUM_PEGS-1:0] claim_q;   // Guess positions already paired
    logic [COUNT_W-1:0]  red_q;
    logic [COUNT_W-1:0]  white_q;
    logic [PEG_W-1:0]    code_k;
    logic                red_hit;
    logic [NUM_PEGS-1:0] cand;
    logic [NUM_PEGS-1:0] pick;

    always_comb begin
        code_k  = code_i[step_idx_i*PEG_W +: PEG_W];
        red_hit = (guess_i[step_idx_i*PEG_W +: PEG_W] == code_k);
        // Exact matches never take part in white pairing
        for (int j = 0; j < NUM_PEGS; j++) begin
            cand[j] = !claim_q[j]
                && (guess_i[j*PEG_W +: PEG_W] != code_i[j*PEG_W +: PEG_W])
                && (guess_i[j*PEG_W +: PEG_W] == code_k);
        end
        pick = cand & (~cand + 1'b1);   // Lowest candidate only
    end

    always_ff @(posedge clock_i) begin
        if (!resetn_i || clear_i) begin
            claim_q <= '0;
            red_q   <= '0;
            white_q <= '0;
        end else if (step_i) begin
            if (red_hit) begin
                red_q <= red_q + 1'b1;
            end else if (|pick) begin
                claim_q <= claim_q | pick;
                white_q <= white_q + 1'b1;
            end
        end
    end

    assign red_o   = red_q;
    assign white_o = white_q;

    assert property (@(posedge clock_i) disable iff (!resetn_i)
        (red_q + white_q) <= NUM_PEGS);

endmodule

// File: verilog/seg7_display.sv
`timescale 1ns/1ps

module seg7_display (
    input  logic [mastermind_pkg::CODE_W-1:0]  guess_i,
    input  logic [mastermind_pkg::COUNT_W-1:0] red_i,
    input  logic [mastermind_pkg::COUNT_W-1:0] white_i,
    output logic [mastermind_pkg::SEG_W-1:0]   hex0_o,
    output logic [mastermind_pkg::SEG_W-1:0]   hex1_o,
    output logic [mastermind_pkg::SEG_W-1:0]   hex2_o,
    output logic [mastermind_pkg::SEG_W-1:0]   hex3_o,
    output logic [mastermind_pkg::SEG_W-1:0]   hex4_o,
    output logic [mastermind_pkg::SEG_W-1:0]   hex5_o
);
    import mastermind_pkg::*;

    // Active low, segment g in the top bit
    function automatic logic [SEG_W-1:0] seg_decode(input logic [PEG_W-1:0] value);
        logic [SEG_W-1:0] seg;
        case (value)
            0:       seg = 7'b100_0000;
            1:       seg = 7'b111_1001;
            2:       seg = 7'b010_0100;
            3:       seg = 7'b011_0000;
            4:       seg = 7'b001_1001;
            5:       seg = 7'b001_0010;
            6:       seg = 7'b000_0010;
            7:       seg = 7'b111_1000;
            default: seg = 7'b111_1111;  // Blank
        endcase
        return seg;
    endfunction

    // Guess pegs in slot order
    assign hex0_o = seg_decode(guess_i[0*PEG_W +: PEG_W]);
    assign hex1_o = seg_decode(guess_i[1*PEG_W +: PEG_W]);
    assign hex2_o = seg_decode(guess_i[2*PEG_W +: PEG_W]);
    assign hex3_o = seg_decode(guess_i[3*PEG_W +: PEG_W]);

    assign hex4_o = seg_decode(PEG_W'(red_i));
    assign hex5_o = seg_decode(PEG_W'(white_i));

endmodule

// File: verilog/mastermind_top.sv
`timescale 1ns/1ps

module mastermind_top #(
    parameter int TICK_CYCLES = mastermind_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic                             clock,
    input  logic                             resetn,
    input  logic                             load_i,
    input  logic [mastermind_pkg::PEG_W-1:0] peg_i,
    output logic [mastermind_pkg::SEG_W-1:0] hex0_o,
    output logic [mastermind_pkg::SEG_W-1:0] hex1_o,
    output logic [mastermind_pkg::SEG_W-1:0] hex2_o,
    output logic [mastermind_pkg::SEG_W-1:0] hex3_o,
    output logic [mastermind_pkg::SEG_W-1:0] hex4_o,
    output logic [mastermind_pkg::SEG_W-1:0] hex5_o,
    output logic                             results_o
);
    import mastermind_pkg::*;

    logic               tick;
    logic               code_we;
    logic               guess_we;
    logic               score_clear;
    logic               score_step;
    logic [SLOT_W-1:0]  slot;
    logic [CODE_W-1:0]  code;
    logic [CODE_W-1:0]  guess;
    logic [COUNT_W-1:0] red;
    logic [COUNT_W-1:0] white;

    tick_timer #(
        .TICK_CYCLES(TICK_CYCLES)
    ) u_tick_timer (
        .clock_i  (clock),
        .resetn_i (resetn),
        .tick_o   (tick)
    );

    game_fsm u_game_fsm (
        .clock_i       (clock),
        .resetn_i      (resetn),
        .tick_i        (tick),
        .load_i        (load_i),
        .code_we_o     (code_we),
        .guess_we_o    (guess_we),
        .score_clear_o (score_clear),
        .score_step_o  (score_step),
        .results_o     (results_o),
        .slot_o        (slot)
    );

    peg_registers u_peg_registers (
        .clock_i    (clock),
        .resetn_i   (resetn),
        .code_we_i  (code_we),
        .guess_we_i (guess_we),
        .slot_i     (slot),
        .peg_i      (peg_i),
        .code_o     (code),
        .guess_o    (guess)
    );

    // Slot is the step index while scoring
    peg_scorer u_peg_scorer (
        .clock_i    (clock),
        .resetn_i   (resetn),
        .clear_i    (score_clear),
        .step_i     (score_step),
        .step_idx_i (slot),
        .code_i     (code),
        .guess_i    (guess),
        .red_o      (red),
        .white_o    (white)
    );

    seg7_display u_seg7_display (
        .guess_i (guess),
        .red_i   (red),
        .white_i (white),
        .hex0_o  (hex0_o),
        .hex1_o  (hex1_o),
        .hex2_o  (hex2_o),
        .hex3_o  (hex3_o),
        .hex4_o  (hex4_o),
        .hex5_o  (hex5_o)
    );

endmodule

// File: testbench/mastermind_tb.sv
`timescale 1ns/1ps

module mastermind_tb;
    import mastermind_pkg::*;

    typedef logic [NUM_PEGS-1:0][PEG_W-1:0] peg_word_t;

    localparam int TB_TICK        = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ROUNDS     = 23;     // Exact, rotation, long press, 20 random
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROUNDS * TB_TICK + RESET_CYCLES;

    // Active low, segment g in the top bit
    localparam logic [SEG_W-1:0] SEG_TABLE [8] = '{
        7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
        7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000
    };

    logic             clock;
    logic             resetn;
    logic             load_i;
    logic [PEG_W-1:0] peg_i;
    logic [SEG_W-1:0] hex [6];
    logic             results_o;

    logic [SEG_W-1:0] exp_hex [6];
    logic             report_due;
    peg_word_t        code_model;
    peg_word_t        guess;
    logic [31:0]      rng;
    string            test_name;
    int               cycle_count;

    mastermind_top #(
        .TICK_CYCLES(TB_TICK)
    ) UUT (
        .clock     (clock),
        .resetn    (resetn),
        .load_i    (load_i),
        .peg_i     (peg_i),
        .hex0_o    (hex[0]),
        .hex1_o    (hex[1]),
        .hex2_o    (hex[2]),
        .hex3_o    (hex[3]),
        .hex4_o    (hex[4]),
        .hex5_o    (hex[5]),
        .results_o (results_o)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic report_mismatch(input string what, input logic [SEG_W-1:0] expected,
                                   input logic [SEG_W-1:0] actual);
        $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, expected, actual);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s (test %s)", what, test_name);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int count_red(input peg_word_t code, input peg_word_t g);
        int red;
        red = 0;
        for (int p = 0; p < NUM_PEGS; p++) begin
            if (code[p] == g[p]) red++;
        end
        return red;
    endfunction

    // Colour matches regardless of position
    function automatic int count_common(input peg_word_t code, input peg_word_t g);
        int total;
        int in_code;
        int in_guess;
        total = 0;
        for (int c = 0; c < 8; c++) begin
            in_code = 0;
            in_guess = 0;
            for (int p = 0; p < NUM_PEGS; p++) begin
                if (code[p] == c) in_code++;
                if (g[p] == c) in_guess++;
            end
            total += (in_code < in_guess) ? in_code : in_guess;
        end
        return total;
    endfunction

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic enter_peg(input logic [PEG_W-1:0] peg, input int hold_ticks);
        peg_i  = peg;
        load_i = 1'b1;
        wait_clocks(hold_ticks * TB_TICK);
        load_i = 1'b0;
        wait_clocks(3 * TB_TICK);
    endtask

    // Peg changes mid press, a second write would show on hex0
    task automatic enter_peg_long(input logic [PEG_W-1:0] peg);
        peg_i  = peg;
        load_i = 1'b1;
        wait_clocks(3 * TB_TICK);
        peg_i = ~peg;
        wait_clocks(12 * TB_TICK);
        load_i = 1'b0;
        wait_clocks(3 * TB_TICK);
    endtask

    task automatic wait_for_report();
        @(negedge clock);
        while (!results_o) @(negedge clock);
        @(posedge clock);
        #1;
        report_due = 1'b0;
    endtask

    task automatic play_round(input string name, input peg_word_t g, input bit long_hold);
        int red;
        int white;
        red = count_red(code_model, g);
        white = count_common(code_model, g) - red;
        test_name = name;
        for (int i = 0; i < NUM_PEGS; i++) begin
            exp_hex[i] = SEG_TABLE[g[i]];
        end
        exp_hex[4] = SEG_TABLE[red];
        exp_hex[5] = SEG_TABLE[white];
        for (int i = 0; i < NUM_PEGS; i++) begin
            if (i == NUM_PEGS - 1) report_due = 1'b1;
            if (i == 0 && long_hold) enter_peg_long(g[i]);
            else enter_peg(g[i], 3);
        end
        wait_for_report();
    endtask

    // Digits against the model on every result pulse
    for (genvar i = 0; i < 6; i++) begin : g_digit_check
        assert property (@(posedge clock) disable iff (!resetn)
            results_o |-> hex[i] == exp_hex[i])
            else report_mismatch($sformatf("hex%0d", i), exp_hex[i], $sampled(hex[i]));
    end

    assert property (@(posedge clock) disable iff (!resetn) results_o |=> !results_o)
        else report_failure("results_o stayed high for more than one clock");

    assert property (@(posedge clock) disable iff (!resetn) results_o |-> report_due)
        else report_failure("results_o pulsed without a complete guess");

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("Timeout, the run took too many clock cycles");
        end
    end

    initial begin
        resetn      = 1'b0;
        load_i      = 1'b0;
        peg_i       = '0;
        report_due  = 1'b0;
        cycle_count = 0;
        rng         = 32'd21;
        test_name   = "reset";
        for (int i = 0; i < 6; i++) begin
            exp_hex[i] = SEG_TABLE[0];
        end
        code_model = {3'd1, 3'd3, 3'd0, 3'd2};  // Four distinct colours
        wait_clocks(RESET_CYCLES);
        resetn = 1'b1;

        @(negedge clock);
        for (int i = 0; i < 6; i++) begin
            assert (hex[i] == SEG_TABLE[0])
                else report_mismatch($sformatf("hex%0d", i), SEG_TABLE[0], hex[i]);
        end
        wait_clocks(1);

        test_name = "code_entry";
        for (int i = 0; i < NUM_PEGS; i++) begin
            enter_peg(code_model[i], 3);
        end

        play_round("exact_match", code_model, 1'b0);
        for (int i = 0; i < NUM_PEGS; i++) begin
            guess[i] = code_model[(i + 1) % NUM_PEGS];
        end
        play_round("rotation", guess, 1'b0);
        play_round("long_press", {3'd2, 3'd1, 3'd3, 3'd3}, 1'b1);

        for (int r = 0; r < 20; r++) begin
            for (int p = 0; p < NUM_PEGS; p++) begin
                rng = xorshift32(rng);
                guess[p] = {1'b0, rng[1:0]};    // Colours 0 to 3 only
            end
            play_round($sformatf("random_%0d", r), guess, 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: all.f
verilog/mastermind_pkg.sv
verilog/tick_timer.sv
verilog/game_fsm.sv
verilog/peg_registers.sv
verilog/peg_scorer.sv
verilog/seg7_display.sv
verilog/mastermind_top.sv
testbench/mastermind_tb.sv

// File: Bender.yml
package:
  name: mastermind

sources:
  - verilog/mastermind_pkg.sv
  - verilog/tick_timer.sv
  - verilog/game_fsm.sv
  - verilog/peg_registers.sv
  - verilog/peg_scorer.sv
  - verilog/seg7_display.sv
  - verilog/mastermind_top.sv
  - target: simulation
    files:
      - testbench/mastermind_tb.sv
